// File: lcst.f
hdl/lc_state_pkg.sv
hdl/sec_state_pkg.sv
hdl/lc_unlock_eval.sv
hdl/sec_state_fsm.sv
hdl/debug_en_gen.sv
hdl/lcst_top.sv
tests/lcst_props.sv
tests/lcst_tb.sv

// File: tests/lcst_vectors.txt
# name vld warm err preq pstate vol dft hw otp manuf level dft_mask dbg_mask cltap_mask
# then exp_lifecycle exp_locked exp_dft_en exp_hw_dbg_en, every field after the name in hex
static_raw            1 0 0 0 00 0 0 0 00 0 0 0 0 0 3 1 0 0
static_test_locked2   1 0 0 0 00 0 0 0 0b 0 0 0 0 0 3 1 0 0
static_test_locked6   1 0 0 0 00 0 0 0 0f 0 0 0 0 0 3 1 0 0
static_test_unlock0   1 0 0 0 00 0 0 0 01 0 0 0 0 0 0 0 0 0
static_test_unlock7   1 0 0 0 00 0 0 0 08 0 0 0 0 0 0 0 0 0
static_dev            1 0 0 0 00 0 0 0 10 0 0 0 0 0 1 1 0 0
static_prod           1 0 0 0 00 0 0 0 11 0 0 0 0 0 3 1 0 0
static_prod_end       1 0 0 0 00 0 0 0 12 0 0 0 0 0 3 1 0 0
static_rma            1 0 0 0 00 0 0 0 13 0 0 0 0 0 3 0 0 0
static_scrap          1 0 0 0 00 0 0 0 14 0 0 0 0 0 3 1 0 0
unlock_dev_manuf      1 0 0 0 00 0 0 0 10 1 0 0 0 0 1 0 0 0
unlock_prod_level     1 0 0 0 00 0 0 0 11 0 4 0 6 0 3 0 0 0
unlock_prod_miss      1 0 0 0 00 0 0 0 11 0 4 0 3 0 3 1 0 0
unlock_raw_volatile   1 0 0 0 00 1 0 0 00 0 0 0 0 0 0 0 0 0
error_rma             1 0 1 0 00 0 0 0 13 0 0 0 0 0 3 1 0 0
error_blocks_volatile 1 0 1 0 00 1 0 0 00 0 0 0 0 0 3 1 0 0
scrap_req_test_unlock 1 0 0 1 14 0 5 5 04 0 0 0 0 0 3 1 0 0
scrap_req_dev_masks   1 0 0 1 14 0 0 0 10 1 1 1 0 1 3 1 0 0
prog_req_not_scrap    1 0 0 1 11 0 5 0 13 0 0 0 0 0 3 0 1 0
enable_dft_on         1 0 0 0 00 0 5 a 11 0 0 0 0 0 3 1 1 0
enable_hw_on          1 0 0 0 00 0 3 5 11 0 0 0 0 0 3 1 0 1
enable_dft_mask       1 0 0 0 00 0 0 0 11 0 8000000000000000 8000000000000001 0 0 3 1 1 0
enable_cltap_mask     1 0 0 0 00 0 0 0 11 0 2 0 0 2 3 1 0 1
enable_no_overlap     1 0 0 0 00 0 a 0 11 0 1 2 2 2 3 1 0 0
warm_rma              1 1 0 0 00 0 5 0 13 0 0 0 0 0 3 1 1 0
warm_test_unlock      1 1 0 0 00 0 0 0 04 0 0 0 0 0 3 1 0 0
warm_dev_manuf        1 1 0 0 00 0 0 0 10 1 0 0 0 0 3 1 0 0
valid_low_rma         0 0 0 0 00 0 5 5 13 0 0 0 0 0 3 1 0 0

// File: tests/lcst_tb.sv
`default_nettype none

module lcst_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int UNLOCK_LEVEL_W = 64;

  // DUT inputs
  logic                           clk;
  logic                           rst_n;
  logic                           warm_reset_warn;
  logic                           state_error;
  logic                           lcc_prog_req;
  lc_state_pkg::lc_state_e        lcc_prog_state;
  logic                           volatile_raw_unlock;
  lc_state_pkg::lc_tx_t           lc_dft_en;
  lc_state_pkg::lc_tx_t           lc_hw_debug_en;
  logic                           otp_valid;
  lc_state_pkg::lc_state_e        otp_lc_state;
  logic                           manuf_dbg_en;
  logic [UNLOCK_LEVEL_W-1:0]      unlock_level;
  logic [UNLOCK_LEVEL_W-1:0]      dft_en_mask;
  logic [UNLOCK_LEVEL_W-1:0]      dbg_unlock_mask;
  logic [UNLOCK_LEVEL_W-1:0]      cltap_unlock_mask;
  // DUT outputs
  logic                           soc_dft_en;
  logic                           soc_hw_debug_en;
  lc_state_pkg::lc_state_e        otp_static_state;
  logic                           otp_state_valid;
  sec_state_pkg::security_state_t security_state;

  string vec_lines[$];
  int    cycle_count = 0;
  int    cycle_limit = 40;
  int    check_errors = 0;
  int    tests_failed = 0;

  lcst_top #(
    .UNLOCK_LEVEL_W (UNLOCK_LEVEL_W)
  ) uut (
    .clk_i                 (clk),
    .rst_ni                (rst_n),
    .warm_reset_warn_i     (warm_reset_warn),
    .state_error_i         (state_error),
    .lcc_prog_req_i        (lcc_prog_req),
    .lcc_prog_state_i      (lcc_prog_state),
    .volatile_raw_unlock_i (volatile_raw_unlock),
    .lc_dft_en_i           (lc_dft_en),
    .lc_hw_debug_en_i      (lc_hw_debug_en),
    .otp_valid_i           (otp_valid),
    .otp_lc_state_i        (otp_lc_state),
    .manuf_dbg_en_i        (manuf_dbg_en),
    .unlock_level_i        (unlock_level),
    .dft_en_mask_i         (dft_en_mask),
    .dbg_unlock_mask_i     (dbg_unlock_mask),
    .cltap_unlock_mask_i   (cltap_unlock_mask),
    .soc_dft_en_o          (soc_dft_en),
    .soc_hw_debug_en_o     (soc_hw_debug_en),
    .otp_static_state_o    (otp_static_state),
    .otp_state_valid_o     (otp_state_valid),
    .security_state_o      (security_state)
  );

  // 20 ns clock
  initial clk = 1'b0;
  always #10 clk = ~clk;

  // ----------------------------------------------------------------------
  // Timeout, about 12 cycles per vector plus reset margin
  // ----------------------------------------------------------------------
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run took more than %0d clock cycles", cycle_limit);
      $display("=== FAIL ===");
      $finish;
    end
  end

  // Keep every non-comment line of the vector file
  task automatic load_vectors();
    int    fd;
    int    code;
    string line;
    fd = $fopen("tests/lcst_vectors.txt", "r");
    if (fd == 0) begin
      $display("could not open the vector file tests/lcst_vectors.txt");
      check_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 1 && line.getc(0) != "#") begin
          vec_lines.push_back(line);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_field(input string test_name, input string field,
                             input logic [63:0] expected, input logic [63:0] actual);
    assert (actual === expected)
      else begin
        $display("error: test %s %s expected %0h actual %0h",
                 test_name, field, expected, actual);
        check_errors++;
      end
  endtask

  // ----------------------------------------------------------------------
  // One vector: valid low, new inputs, valid back, wait, check
  // ----------------------------------------------------------------------
  task automatic run_vector(input string line);
    string       name;
    logic [63:0] vld, warm, err, preq, pstate, vol, dft, hw, otp, manuf;
    logic [63:0] level, dmask, dbgmask, cmask;
    logic [63:0] exp_lc, exp_lk, exp_dft, exp_hw;
    logic [4:0]  exp_static;
    int          n;
    int          errs_before;
    errs_before = check_errors;
    n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                name, vld, warm, err, preq, pstate, vol, dft, hw, otp, manuf,
                level, dmask, dbgmask, cmask, exp_lc, exp_lk, exp_dft, exp_hw);
    if (n != 19) begin
      $display("vector line could not be parsed: %s", line);
      check_errors++;
      tests_failed++;
    end else begin
      // Two edges with valid low reset the translator
      @(posedge clk);
      otp_valid <= 1'b0;
      @(posedge clk);
      // One edge after valid fell every output is back at its default
      @(negedge clk);
      check_field(name, "idle_lifecycle", 64'h3, security_state[2:1]);
      check_field(name, "idle_debug_locked", 64'h1, security_state.debug_locked);
      check_field(name, "idle_dft_en", 64'h0, soc_dft_en);
      check_field(name, "idle_hw_debug_en", 64'h0, soc_hw_debug_en);
      check_field(name, "idle_static_state", 64'h0, otp_static_state);
      check_field(name, "idle_valid_echo", 64'h0, otp_state_valid);
      @(posedge clk);
      warm_reset_warn     <= warm[0];
      state_error         <= err[0];
      lcc_prog_req        <= preq[0];
      lcc_prog_state      <= lc_state_pkg::lc_state_e'(pstate[4:0]);
      volatile_raw_unlock <= vol[0];
      lc_dft_en           <= dft[3:0];
      lc_hw_debug_en      <= hw[3:0];
      otp_lc_state        <= lc_state_pkg::lc_state_e'(otp[4:0]);
      manuf_dbg_en        <= manuf[0];
      unlock_level        <= level;
      dft_en_mask         <= dmask;
      dbg_unlock_mask     <= dbgmask;
      cltap_unlock_mask   <= cmask;
      @(posedge clk);
      otp_valid <= vld[0];
      // Well past the 4 edge settling bound
      repeat (8) @(posedge clk);
      @(negedge clk);
      // Static state follows the fuse input only while valid
      exp_static = vld[0] ? otp[4:0] : 5'd0;
      check_field(name, "lifecycle", exp_lc, security_state[2:1]);
      check_field(name, "debug_locked", exp_lk, security_state.debug_locked);
      check_field(name, "dft_en", exp_dft, soc_dft_en);
      check_field(name, "hw_debug_en", exp_hw, soc_hw_debug_en);
      check_field(name, "static_state", exp_static, otp_static_state);
      check_field(name, "valid_echo", vld[0], otp_state_valid);
      if (check_errors == errs_before) begin
        $display("test %s passed", name);
      end else begin
        $display("test %s failed", name);
        tests_failed++;
      end
    end
  endtask

  initial begin
    rst_n               = 1'b0;
    warm_reset_warn     = 1'b0;
    state_error         = 1'b0;
    lcc_prog_req        = 1'b0;
    lcc_prog_state      = lc_state_pkg::LC_ST_RAW;
    volatile_raw_unlock = 1'b0;
    lc_dft_en           = '0;
    lc_hw_debug_en      = '0;
    otp_valid           = 1'b0;
    otp_lc_state        = lc_state_pkg::LC_ST_RAW;
    manuf_dbg_en        = 1'b0;
    unlock_level        = '0;
    dft_en_mask         = '0;
    dbg_unlock_mask     = '0;
    cltap_unlock_mask   = '0;
    load_vectors();
    cycle_limit = vec_lines.size() * 12 + 40;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    foreach (vec_lines[i]) begin
      run_vector(vec_lines[i]);
    end
    $display("tests run %0d, tests failed %0d, failed checks %0d",
             vec_lines.size(), tests_failed, check_errors);
    if (check_errors == 0 && vec_lines.size() > 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/lcst_props.sv
`default_nettype none

module lcst_props (
  input wire logic                           clk_i,
  input wire logic                           rst_ni,
  input wire logic                           otp_valid_i,
  input wire logic                           warm_reset_warn_i,
  input wire logic                           lcc_prog_req_i,
  input wire lc_state_pkg::lc_state_e        lcc_prog_state_i,
  input wire logic                           soc_dft_en_o,
  input wire logic                           soc_hw_debug_en_o,
  input wire sec_state_pkg::security_state_t security_state_o
);

  timeunit 1ns;
  timeprecision 1ps;

  // LC controller programming SCRAP
  logic scrap_seen;

  assign scrap_seen = lcc_prog_req_i && (lcc_prog_state_i == lc_state_pkg::LC_ST_SCRAP);

  // ----------------------------------------------------------------------
  // Enable gating
  // ----------------------------------------------------------------------
  valid_low_clears_enables: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !otp_valid_i |=> (!soc_dft_en_o && !soc_hw_debug_en_o)
  ) else $error("SoC enables still high one cycle after valid dropped");

  // Scrap closes both enables on the next edge
  scrap_clears_enables: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    scrap_seen |=> (!soc_dft_en_o && !soc_hw_debug_en_o)
  ) else $error("SoC enables still high one cycle after a scrap request");

  // ----------------------------------------------------------------------
  // Warm reset override
  // ----------------------------------------------------------------------
  warm_reset_locks: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (warm_reset_warn_i && otp_valid_i) |=>
      (security_state_o == sec_state_pkg::SEC_STATE_LOCKED)
  ) else $error("security state not locked production after a warm reset warning");

endmodule

bind lcst_top lcst_props u_props (
  .clk_i             (clk_i),
  .rst_ni            (rst_ni),
  .otp_valid_i       (otp_valid_i),
  .warm_reset_warn_i (warm_reset_warn_i),
  .lcc_prog_req_i    (lcc_prog_req_i),
  .lcc_prog_state_i  (lcc_prog_state_i),
  .soc_dft_en_o      (soc_dft_en_o),
  .soc_hw_debug_en_o (soc_hw_debug_en_o),
  .security_state_o  (security_state_o)
);

`default_nettype wire

// File: hdl/lcst_top.sv
`default_nettype none

module lcst_top #(
  parameter int UNLOCK_LEVEL_W = 64
) (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      warm_reset_warn_i,
  input  wire logic                      state_error_i,
  input  wire logic                      lcc_prog_req_i,
  input  wire lc_state_pkg::lc_state_e   lcc_prog_state_i,
  input  wire logic                      volatile_raw_unlock_i,
  input  wire lc_state_pkg::lc_tx_t      lc_dft_en_i,
  input  wire lc_state_pkg::lc_tx_t      lc_hw_debug_en_i,
  input  wire logic                      otp_valid_i,
  input  wire lc_state_pkg::lc_state_e   otp_lc_state_i,
  input  wire logic                      manuf_dbg_en_i,
  input  wire logic [UNLOCK_LEVEL_W-1:0] unlock_level_i,
  input  wire logic [UNLOCK_LEVEL_W-1:0] dft_en_mask_i,
  input  wire logic [UNLOCK_LEVEL_W-1:0] dbg_unlock_mask_i,
  input  wire logic [UNLOCK_LEVEL_W-1:0] cltap_unlock_mask_i,
  output logic                           soc_dft_en_o,
  output logic                           soc_hw_debug_en_o,
  output lc_state_pkg::lc_state_e        otp_static_state_o,
  output logic                           otp_state_valid_o,
  output sec_state_pkg::security_state_t security_state_o
);

  // Grants and scrap request, shared by FSM and enable logic
  logic dft_unlock;
  logic hw_dbg_unlock;
  logic prod_unlock;
  logic scrap_req;

  // Valid echo back to the SoC
  assign otp_state_valid_o = otp_valid_i;

  // ----------------------------------------------------------------------
  // Wide mask datapath
  // ----------------------------------------------------------------------
  lc_unlock_eval #(
    .UNLOCK_LEVEL_W (UNLOCK_LEVEL_W)
  ) u_unlock_eval (
    .unlock_level_i      (unlock_level_i),
    .dft_en_mask_i       (dft_en_mask_i),
    .dbg_unlock_mask_i   (dbg_unlock_mask_i),
    .cltap_unlock_mask_i (cltap_unlock_mask_i),
    .lcc_prog_req_i      (lcc_prog_req_i),
    .lcc_prog_state_i    (lcc_prog_state_i),
    .dft_unlock_o        (dft_unlock),
    .hw_dbg_unlock_o     (hw_dbg_unlock),
    .prod_unlock_o       (prod_unlock),
    .scrap_req_o         (scrap_req)
  );

  // ----------------------------------------------------------------------
  // Security state translator
  // ----------------------------------------------------------------------
  sec_state_fsm u_sec_state_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .otp_valid_i           (otp_valid_i),
    .otp_lc_state_i        (otp_lc_state_i),
    .warm_reset_warn_i     (warm_reset_warn_i),
    .state_error_i         (state_error_i),
    .scrap_req_i           (scrap_req),
    .volatile_raw_unlock_i (volatile_raw_unlock_i),
    .manuf_dbg_en_i        (manuf_dbg_en_i),
    .prod_unlock_i         (prod_unlock),
    .otp_static_state_o    (otp_static_state_o),
    .security_state_o      (security_state_o)
  );

  // SoC DFT and hardware debug enables
  debug_en_gen u_debug_en_gen (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .otp_valid_i       (otp_valid_i),
    .lc_dft_en_i       (lc_dft_en_i),
    .lc_hw_debug_en_i  (lc_hw_debug_en_i),
    .dft_unlock_i      (dft_unlock),
    .hw_dbg_unlock_i   (hw_dbg_unlock),
    .scrap_req_i       (scrap_req),
    .soc_dft_en_o      (soc_dft_en_o),
    .soc_hw_debug_en_o (soc_hw_debug_en_o)
  );

endmodule

`default_nettype wire

// File: hdl/debug_en_gen.sv
`default_nettype none

module debug_en_gen (
  input  wire logic                 clk_i,
  input  wire logic                 rst_ni,
  input  wire logic                 otp_valid_i,
  input  wire lc_state_pkg::lc_tx_t lc_dft_en_i,
  input  wire lc_state_pkg::lc_tx_t lc_hw_debug_en_i,
  input  wire logic                 dft_unlock_i,
  input  wire logic                 hw_dbg_unlock_i,
  input  wire logic                 scrap_req_i,
  output logic                      soc_dft_en_o,
  output logic                      soc_hw_debug_en_o
);

  logic dft_en_d;
  logic hw_debug_en_d;

  // ----------------------------------------------------------------------
  // Enable decode
  // ----------------------------------------------------------------------
  // LC enable must be exactly ON, a mask grant also opens it
  // Pending scrap closes both
  assign dft_en_d = ((lc_dft_en_i == lc_state_pkg::LC_TX_ON) || dft_unlock_i) &&
                    !scrap_req_i;
  assign hw_debug_en_d = ((lc_hw_debug_en_i == lc_state_pkg::LC_TX_ON) || hw_dbg_unlock_i) &&
                         !scrap_req_i;

  // Output flops, cleared while valid is low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end else if (otp_valid_i) begin
      soc_dft_en_o      <= dft_en_d;
      soc_hw_debug_en_o <= hw_debug_en_d;
    end else begin
      soc_dft_en_o      <= 1'b0;
      soc_hw_debug_en_o <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: hdl/sec_state_fsm.sv
`default_nettype none

module sec_state_fsm (
  input  wire logic                      clk_i,
  input  wire logic                      rst_ni,
  input  wire logic                      otp_valid_i,
  input  wire lc_state_pkg::lc_state_e   otp_lc_state_i,
  input  wire logic                      warm_reset_warn_i,
  input  wire logic                      state_error_i,
  input  wire logic                      scrap_req_i,
  input  wire logic                      volatile_raw_unlock_i,
  input  wire logic                      manuf_dbg_en_i,
  input  wire logic                      prod_unlock_i,
  output lc_state_pkg::lc_state_e        otp_static_state_o,
  output sec_state_pkg::security_state_t security_state_o
);

  sec_state_pkg::xlat_state_e     state_q;
  sec_state_pkg::xlat_state_e     state_d;
  sec_state_pkg::security_state_t sec_state_d;

  // Escape condition shared by all decoded states
  logic force_lock;

  assign force_lock = state_error_i || scrap_req_i;

  // ----------------------------------------------------------------------
  // Registers
  // ----------------------------------------------------------------------
  // Everything falls back to the locked default while valid is low
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q            <= sec_state_pkg::RESET;
      security_state_o   <= sec_state_pkg::SEC_STATE_LOCKED;
      otp_static_state_o <= lc_state_pkg::LC_ST_RAW;
    end else if (otp_valid_i) begin
      state_q            <= state_d;
      otp_static_state_o <= otp_lc_state_i;
      // Warm reset warning wins over the decoded state
      if (warm_reset_warn_i) begin
        security_state_o <= sec_state_pkg::SEC_STATE_LOCKED;
      end else begin
        security_state_o <= sec_state_d;
      end
    end else begin
      state_q            <= sec_state_pkg::RESET;
      security_state_o   <= sec_state_pkg::SEC_STATE_LOCKED;
      otp_static_state_o <= lc_state_pkg::LC_ST_RAW;
    end
  end

  // ----------------------------------------------------------------------
  // Next state and security state decode
  // ----------------------------------------------------------------------
  always_comb begin
    // Defaults hold the state and report locked production
    state_d     = state_q;
    sec_state_d = sec_state_pkg::SEC_STATE_LOCKED;

    case (state_q)
      sec_state_pkg::RESET: begin
        state_d = sec_state_pkg::IDLE;
      end

      sec_state_pkg::IDLE: begin
        // Decode the captured fuse state
        if (force_lock || (otp_static_state_o == lc_state_pkg::LC_ST_SCRAP)) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else if ((otp_static_state_o == lc_state_pkg::LC_ST_RAW) ||
                     (otp_static_state_o inside {[lc_state_pkg::LC_ST_TEST_LOCKED0 :
                                                  lc_state_pkg::LC_ST_TEST_LOCKED6]})) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else if (otp_static_state_o inside {[lc_state_pkg::LC_ST_TEST_UNLOCKED0 :
                                                 lc_state_pkg::LC_ST_TEST_UNLOCKED7]}) begin
          state_d = sec_state_pkg::UNPROV_DEBUG;
        end else if (otp_static_state_o == lc_state_pkg::LC_ST_DEV) begin
          state_d = sec_state_pkg::MANUF_NON_DEBUG;
        end else if ((otp_static_state_o == lc_state_pkg::LC_ST_PROD) ||
                     (otp_static_state_o == lc_state_pkg::LC_ST_PROD_END)) begin
          state_d = sec_state_pkg::PROD_NON_DEBUG;
        end else if (otp_static_state_o == lc_state_pkg::LC_ST_RMA) begin
          state_d = sec_state_pkg::PROD_DEBUG;
        end else begin
          // Invalid code, keep waiting
          state_d = sec_state_pkg::IDLE;
        end
      end

      sec_state_pkg::NON_DEBUG: begin
        // Sticky, only a clean volatile unlock leaves it
        if (volatile_raw_unlock_i && !force_lock) begin
          state_d = sec_state_pkg::UNPROV_DEBUG;
        end
      end

      sec_state_pkg::UNPROV_DEBUG: begin
        if (force_lock) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          sec_state_d.device_lifecycle = sec_state_pkg::UNPROVISIONED;
          sec_state_d.debug_locked     = 1'b0;
        end
      end

      sec_state_pkg::MANUF_NON_DEBUG: begin
        if (force_lock) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          // Stays locked for this cycle even when unlocking
          sec_state_d.device_lifecycle = sec_state_pkg::MANUFACTURING;
          if (manuf_dbg_en_i) begin
            state_d = sec_state_pkg::MANUF_DEBUG;
          end
        end
      end

      sec_state_pkg::MANUF_DEBUG: begin
        if (force_lock) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          sec_state_d.device_lifecycle = sec_state_pkg::MANUFACTURING;
          sec_state_d.debug_locked     = 1'b0;
        end
      end

      sec_state_pkg::PROD_NON_DEBUG: begin
        if (force_lock) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else if (prod_unlock_i) begin
          state_d = sec_state_pkg::PROD_DEBUG;
        end
      end

      sec_state_pkg::PROD_DEBUG: begin
        if (force_lock) begin
          state_d = sec_state_pkg::NON_DEBUG;
        end else begin
          sec_state_d.debug_locked = 1'b0;
        end
      end

      default: begin
        state_d = sec_state_pkg::IDLE;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hdl/lc_unlock_eval.sv
`default_nettype none

module lc_unlock_eval #(
  parameter int UNLOCK_LEVEL_W = 64
) (
  input  wire logic [UNLOCK_LEVEL_W-1:0] unlock_level_i,
  input  wire logic [UNLOCK_LEVEL_W-1:0] dft_en_mask_i,
  input  wire logic [UNLOCK_LEVEL_W-1:0] dbg_unlock_mask_i,
  input  wire logic [UNLOCK_LEVEL_W-1:0] cltap_unlock_mask_i,
  input  wire logic                      lcc_prog_req_i,
  input  wire lc_state_pkg::lc_state_e   lcc_prog_state_i,
  output logic                           dft_unlock_o,
  output logic                           hw_dbg_unlock_o,
  output logic                           prod_unlock_o,
  output logic                           scrap_req_o
);

  // ----------------------------------------------------------------------
  // Mask reductions
  // ----------------------------------------------------------------------
  // Level bits granted by each SoC mask register
  logic [UNLOCK_LEVEL_W-1:0] dft_hit;
  logic [UNLOCK_LEVEL_W-1:0] hw_dbg_hit;
  logic [UNLOCK_LEVEL_W-1:0] prod_hit;

  assign dft_hit    = unlock_level_i & dft_en_mask_i;
  assign hw_dbg_hit = unlock_level_i & cltap_unlock_mask_i;
  assign prod_hit   = unlock_level_i & dbg_unlock_mask_i;

  // Any overlapping bit grants the unlock
  assign dft_unlock_o    = |dft_hit;
  assign hw_dbg_unlock_o = |hw_dbg_hit;
  assign prod_unlock_o   = |prod_hit;

  // ----------------------------------------------------------------------
  // Scrap request detection
  // ----------------------------------------------------------------------
  // LC controller is programming the SCRAP state right now
  assign scrap_req_o = lcc_prog_req_i &&
                       (lcc_prog_state_i == lc_state_pkg::LC_ST_SCRAP);

endmodule

`default_nettype wire

// File: hdl/sec_state_pkg.sv
`default_nettype none

package sec_state_pkg;

  // ----------------------------------------------------------------------
  // Translator FSM states
  // ----------------------------------------------------------------------
  typedef enum logic [2:0] {
    RESET,
    IDLE,
    // Sticky locked state, left only through a volatile raw unlock
    NON_DEBUG,
    UNPROV_DEBUG,
    MANUF_NON_DEBUG,
    MANUF_DEBUG,
    PROD_NON_DEBUG,
    PROD_DEBUG
  } xlat_state_e;

  // ----------------------------------------------------------------------
  // Core security state seen by the crypto core
  // ----------------------------------------------------------------------
  // Code 2 is unused
  typedef enum logic [1:0] {
    UNPROVISIONED = 2'd0,
    MANUFACTURING = 2'd1,
    PRODUCTION    = 2'd3
  } device_lifecycle_e;

  typedef struct packed {
    device_lifecycle_e device_lifecycle;
    logic              debug_locked;
  } security_state_t;

  // Safe default, production with debug locked
  parameter security_state_t SEC_STATE_LOCKED = '{
    device_lifecycle: PRODUCTION,
    debug_locked:     1'b1
  };

endpackage

`default_nettype wire

// File: hdl/lc_state_pkg.sv
`default_nettype none

package lc_state_pkg;

  // ----------------------------------------------------------------------
  // Lifecycle states as stored in fuses and driven by the LC controller
  // ----------------------------------------------------------------------
  // Compact 5-bit encoding, codes above SCRAP are invalid
  typedef enum logic [4:0] {
    LC_ST_RAW            = 5'd0,
    LC_ST_TEST_UNLOCKED0 = 5'd1,
    LC_ST_TEST_UNLOCKED1 = 5'd2,
    LC_ST_TEST_UNLOCKED2 = 5'd3,
    LC_ST_TEST_UNLOCKED3 = 5'd4,
    LC_ST_TEST_UNLOCKED4 = 5'd5,
    LC_ST_TEST_UNLOCKED5 = 5'd6,
    LC_ST_TEST_UNLOCKED6 = 5'd7,
    LC_ST_TEST_UNLOCKED7 = 5'd8,
    LC_ST_TEST_LOCKED0   = 5'd9,
    LC_ST_TEST_LOCKED1   = 5'd10,
    LC_ST_TEST_LOCKED2   = 5'd11,
    LC_ST_TEST_LOCKED3   = 5'd12,
    LC_ST_TEST_LOCKED4   = 5'd13,
    LC_ST_TEST_LOCKED5   = 5'd14,
    LC_ST_TEST_LOCKED6   = 5'd15,
    LC_ST_DEV            = 5'd16,
    LC_ST_PROD           = 5'd17,
    LC_ST_PROD_END       = 5'd18,
    LC_ST_RMA            = 5'd19,
    LC_ST_SCRAP          = 5'd20
  } lc_state_e;

  // ----------------------------------------------------------------------
  // Multi-bit booleans from the LC controller
  // ----------------------------------------------------------------------
  typedef logic [3:0] lc_tx_t;

  // Only this pattern means true, anything else is false
  parameter lc_tx_t LC_TX_ON = 4'b0101;

endpackage

`default_nettype wire
